// ==== rv_pkg.sv ====
`default_nettype none

package rv_pkg;

    localparam logic [6:0] OP_R      = 7'b0110011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_JALR   = 7'b1100111;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_LUI    = 7'b0110111;

    localparam logic [31:0] RESET_PC = 32'h0000_0000;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASS_B  // lui
    } alu_op_t;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_fmt_t;

    typedef struct packed {
        logic [19:0] imm;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    // one fetched word, viewed per format
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
        b_fmt_t b;
        j_fmt_t j;
        u_fmt_t u;
    } instr_t;

endpackage

`default_nettype wire

// ==== control_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module control_unit (
    input  rv_pkg::instr_t  instr,
    output logic [4:0]      rs1,
    output logic [4:0]      rs2,
    output logic [4:0]      rd,
    output logic [2:0]      funct3,
    output logic [31:0]     imm,
    output rv_pkg::alu_op_t alu_op,
    output logic            alu_src,
    output logic            mem_to_reg,
    output logic            reg_write,
    output logic            mem_write,
    output logic            branch,
    output logic            jal,
    output logic            jalr
);

    logic writes_rd;

    // funct3 plus bit 30 to alu operation
    function automatic rv_pkg::alu_op_t alu_decode(input logic [2:0] f3, input logic alt);
        rv_pkg::alu_op_t op;
        case (f3)
            3'b000:  op = alt ? rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
            3'b001:  op = rv_pkg::ALU_SLL;
            3'b010:  op = rv_pkg::ALU_SLT;
            3'b011:  op = rv_pkg::ALU_SLTU;
            3'b100:  op = rv_pkg::ALU_XOR;
            3'b101:  op = alt ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
            3'b110:  op = rv_pkg::ALU_OR;
            default: op = rv_pkg::ALU_AND;
        endcase
        return op;
    endfunction

    always_comb
    begin
        rs1        = 5'd0;
        rs2        = 5'd0;
        rd         = 5'd0;
        funct3     = 3'd0;
        imm        = 32'd0;
        alu_op     = rv_pkg::ALU_ADD;
        alu_src    = 1'b0;
        mem_to_reg = 1'b0;
        writes_rd  = 1'b0;
        mem_write  = 1'b0;
        branch     = 1'b0;
        jal        = 1'b0;
        jalr       = 1'b0;
        case (instr.r.opcode)
            rv_pkg::OP_R:
            begin
                rs1       = instr.r.rs1;
                rs2       = instr.r.rs2;
                rd        = instr.r.rd;
                funct3    = instr.r.funct3;
                alu_op    = alu_decode(instr.r.funct3, instr.r.funct7[5]);
                writes_rd = 1'b1;
            end
            rv_pkg::OP_IMM:
            begin
                rs1       = instr.i.rs1;
                rd        = instr.i.rd;
                funct3    = instr.i.funct3;
                imm       = {{20{instr.i.imm[11]}}, instr.i.imm};
                // bit 30 only selects srai here
                alu_op    = alu_decode(instr.i.funct3,
                                       instr.r.funct7[5] && instr.i.funct3 == 3'b101);
                alu_src   = 1'b1;
                writes_rd = 1'b1;
            end
            rv_pkg::OP_LOAD:
            begin
                rs1        = instr.i.rs1;
                rd         = instr.i.rd;
                funct3     = instr.i.funct3;
                imm        = {{20{instr.i.imm[11]}}, instr.i.imm};
                alu_src    = 1'b1;
                mem_to_reg = 1'b1;
                writes_rd  = 1'b1;
            end
            rv_pkg::OP_JALR:
            begin
                rs1       = instr.i.rs1;
                rd        = instr.i.rd;
                funct3    = instr.i.funct3;
                imm       = {{20{instr.i.imm[11]}}, instr.i.imm};
                alu_src   = 1'b1;
                writes_rd = 1'b1;
                jalr      = 1'b1;
            end
            rv_pkg::OP_STORE:
            begin
                rs1       = instr.s.rs1;
                rs2       = instr.s.rs2;
                funct3    = instr.s.funct3;
                imm       = {{20{instr.s.imm_hi[6]}}, instr.s.imm_hi, instr.s.imm_lo};
                alu_src   = 1'b1;
                mem_write = 1'b1;
            end
            rv_pkg::OP_BRANCH:
            begin
                rs1    = instr.b.rs1;
                rs2    = instr.b.rs2;
                funct3 = instr.b.funct3;
                imm    = {{19{instr.b.imm12}}, instr.b.imm12, instr.b.imm11,
                          instr.b.imm10_5, instr.b.imm4_1, 1'b0};
                branch = 1'b1;
            end
            rv_pkg::OP_JAL:
            begin
                rd        = instr.j.rd;
                imm       = {{11{instr.j.imm20}}, instr.j.imm20, instr.j.imm19_12,
                             instr.j.imm11, instr.j.imm10_1, 1'b0};
                writes_rd = 1'b1;
                jal       = 1'b1;
            end
            rv_pkg::OP_LUI:
            begin
                rd        = instr.u.rd;
                imm       = {instr.u.imm, 12'd0};
                alu_op    = rv_pkg::ALU_PASS_B;
                alu_src   = 1'b1;
                writes_rd = 1'b1;
            end
            default:
            begin
                writes_rd = 1'b0;  // unknown opcode is a no-op
            end
        endcase
        reg_write = writes_rd && (rd != 5'd0);  // x0 never written
    end

endmodule

`default_nettype wire

// ==== reg_file.sv ====
`timescale 1ns/1ps
`default_nettype none

module reg_file (
    input  logic        clk,
    input  logic        rst,
    input  logic [4:0]  rs1,
    input  logic [4:0]  rs2,
    input  logic [4:0]  rd,
    input  logic [31:0] wdata,
    input  logic        we,
    output logic [31:0] rs1_data,
    output logic [31:0] rs2_data
);

    logic [31:0] regs [1:31];  // x0 has no storage

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int k = 1; k < 32; k++)
            begin
                regs[k] <= 32'd0;
            end
        end
        else if (we)
        begin
            regs[rd] <= wdata;
        end
    end

    assign rs1_data = (rs1 == 5'd0) ? 32'd0 : regs[rs1];
    assign rs2_data = (rs2 == 5'd0) ? 32'd0 : regs[rs2];

endmodule

`default_nettype wire

// ==== alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  logic [31:0]     a,
    input  logic [31:0]     b,
    input  rv_pkg::alu_op_t op,
    output logic [31:0]     result
);

    logic [4:0] shamt;

    assign shamt = b[4:0];

    always_comb
    begin
        case (op)
            rv_pkg::ALU_ADD:    result = a + b;
            rv_pkg::ALU_SUB:    result = a - b;
            rv_pkg::ALU_SLL:    result = a << shamt;
            rv_pkg::ALU_SLT:    result = {31'd0, $signed(a) < $signed(b)};
            rv_pkg::ALU_SLTU:   result = {31'd0, a < b};
            rv_pkg::ALU_XOR:    result = a ^ b;
            rv_pkg::ALU_SRL:    result = a >> shamt;
            rv_pkg::ALU_SRA:    result = $unsigned($signed(a) >>> shamt);  // keeps sign
            rv_pkg::ALU_OR:     result = a | b;
            rv_pkg::ALU_AND:    result = a & b;
            rv_pkg::ALU_PASS_B: result = b;
            default:            result = 32'd0;
        endcase
    end

endmodule

`default_nettype wire

// ==== pc_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module pc_unit (
    input  logic        clk,
    input  logic        rst,
    input  logic        branch,
    input  logic        jal,
    input  logic        jalr,
    input  logic [2:0]  funct3,
    input  logic [31:0] rs1_data,
    input  logic [31:0] rs2_data,
    input  logic [31:0] imm,
    output logic [31:0] pc,
    output logic [31:0] pc_plus4
);

    logic        taken;
    logic [31:0] jalr_sum;
    logic [31:0] next_pc;

    always_comb
    begin
        case (funct3)
            3'b000:  taken = (rs1_data == rs2_data);  // beq
            3'b001:  taken = (rs1_data != rs2_data);
            3'b100:  taken = ($signed(rs1_data) < $signed(rs2_data));
            3'b101:  taken = ($signed(rs1_data) >= $signed(rs2_data));
            3'b110:  taken = (rs1_data < rs2_data);   // bltu
            3'b111:  taken = (rs1_data >= rs2_data);
            default: taken = 1'b0;
        endcase
    end

    assign pc_plus4 = pc + 32'd4;
    assign jalr_sum = rs1_data + imm;

    always_comb
    begin
        if (jalr)
            next_pc = {jalr_sum[31:1], 1'b0};
        else if (jal || (branch && taken))
            next_pc = pc + imm;
        else
            next_pc = pc_plus4;
    end

    always_ff @(posedge clk)
    begin
        if (rst)
            pc <= rv_pkg::RESET_PC;
        else
            pc <= next_pc;
    end

endmodule

`default_nettype wire

// ==== data_mem.sv ====
`timescale 1ns/1ps
`default_nettype none

module data_mem #(
    parameter int DMEM_WORDS = 64
) (
    input  logic        clk,
    input  logic        rst,
    input  logic [31:0] addr,
    input  logic [31:0] wdata,
    input  logic        we,
    output logic [31:0] rdata
);

    localparam int IDX_W = (DMEM_WORDS > 1) ? $clog2(DMEM_WORDS) : 1;

    logic [31:0]      mem [DMEM_WORDS];
    logic [IDX_W-1:0] idx;

    assign idx = addr[IDX_W+1:2];  // byte offset dropped, upper bits wrap

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int k = 0; k < DMEM_WORDS; k++)
            begin
                mem[k] <= 32'd0;
            end
        end
        else if (we)
        begin
            mem[idx] <= wdata;
        end
    end

    assign rdata = mem[idx];

endmodule

`default_nettype wire

// ==== rv_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_core #(
    parameter int DMEM_WORDS = 64
) (
    input  logic        clk,
    input  logic        rst,
    input  logic [31:0] instr,
    output logic [31:0] pc,
    output logic        wb_en,
    output logic [4:0]  wb_rd,
    output logic [31:0] wb_data
);

    logic [4:0]      rs1;
    logic [4:0]      rs2;
    logic [4:0]      rd;
    logic [2:0]      funct3;
    logic [31:0]     imm;
    rv_pkg::alu_op_t alu_op;
    logic            alu_src;
    logic            mem_to_reg;
    logic            reg_write;
    logic            mem_write;
    logic            branch;
    logic            jal;
    logic            jalr;
    logic [31:0]     rs1_data;
    logic [31:0]     rs2_data;
    logic [31:0]     alu_b;
    logic [31:0]     alu_result;
    logic [31:0]     load_data;
    logic [31:0]     pc_plus4;
    logic            mem_we;

    control_unit i_control_unit (
        .instr      (instr),
        .rs1        (rs1),
        .rs2        (rs2),
        .rd         (rd),
        .funct3     (funct3),
        .imm        (imm),
        .alu_op     (alu_op),
        .alu_src    (alu_src),
        .mem_to_reg (mem_to_reg),
        .reg_write  (reg_write),
        .mem_write  (mem_write),
        .branch     (branch),
        .jal        (jal),
        .jalr       (jalr)
    );

    // no writes while held in reset
    assign wb_en  = reg_write && !rst;
    assign mem_we = mem_write && !rst;
    assign wb_rd  = rd;

    reg_file i_reg_file (
        .clk      (clk),
        .rst      (rst),
        .rs1      (rs1),
        .rs2      (rs2),
        .rd       (rd),
        .wdata    (wb_data),
        .we       (wb_en),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    assign alu_b = alu_src ? imm : rs2_data;

    alu i_alu (
        .a      (rs1_data),
        .b      (alu_b),
        .op     (alu_op),
        .result (alu_result)
    );

    pc_unit i_pc_unit (
        .clk      (clk),
        .rst      (rst),
        .branch   (branch),
        .jal      (jal),
        .jalr     (jalr),
        .funct3   (funct3),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .imm      (imm),
        .pc       (pc),
        .pc_plus4 (pc_plus4)
    );

    data_mem #(
        .DMEM_WORDS (DMEM_WORDS)
    ) i_data_mem (
        .clk   (clk),
        .rst   (rst),
        .addr  (alu_result),
        .wdata (rs2_data),
        .we    (mem_we),
        .rdata (load_data)
    );

    always_comb
    begin
        if (jal || jalr)
            wb_data = pc_plus4;  // link address
        else if (mem_to_reg)
            wb_data = load_data;
        else
            wb_data = alu_result;
    end

endmodule

`default_nettype wire

// ==== tb_rv_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_rv_core;

    localparam int CLK_PERIOD   = 100;
    localparam int RESET_CYCLES = 4;
    localparam int NUM_INSTR    = 2000;
    localparam int MAX_CYCLES   = NUM_INSTR + RESET_CYCLES + 96;
    localparam int DMEM_WORDS   = 64;

    logic        clk;
    logic        rst;
    logic [31:0] instr;
    logic [31:0] pc;
    logic        wb_en;
    logic [4:0]  wb_rd;
    logic [31:0] wb_data;

    logic [31:0] lfsr;
    int          cycles;
    logic [31:0] m_regs [32];  // model state
    logic [31:0] m_mem [DMEM_WORDS];
    logic [31:0] m_pc;

    rv_core #(
        .DMEM_WORDS (DMEM_WORDS)
    ) i_rv_core (
        .clk     (clk),
        .rst     (rst),
        .instr   (instr),
        .pc      (pc),
        .wb_en   (wb_en),
        .wb_rd   (wb_rd),
        .wb_data (wb_data)
    );

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk)
    begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES)
        begin
            $display("test did not finish within %0d cycles", MAX_CYCLES);
            $display("Done: errors found");
            $fatal(1, "timeout");
        end
    end

    // taps 32 22 2 1
    function automatic logic next_bit();
        logic fb;
        fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
        lfsr = {lfsr[30:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = 32'd0;
        for (int k = 0; k < n; k++)
        begin
            v = {v[30:0], next_bit()};
        end
        return v;
    endfunction

    task automatic compare(input string what, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp)
        begin
            $display("mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
            $display("Done: errors found");
            $fatal(1, "compare failed");
        end
    endtask

    function automatic logic is_supported(input logic [6:0] op);
        return op == rv_pkg::OP_R || op == rv_pkg::OP_IMM || op == rv_pkg::OP_LOAD
            || op == rv_pkg::OP_JALR || op == rv_pkg::OP_STORE || op == rv_pkg::OP_BRANCH
            || op == rv_pkg::OP_JAL || op == rv_pkg::OP_LUI;
    endfunction

    function automatic logic [31:0] alu_model(input logic [2:0] f3, input logic alt,
                                              input logic [31:0] a, input logic [31:0] b);
        logic signed [31:0] sra;
        sra = $signed(a) >>> b[4:0];
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << b[4:0];
            3'd2:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3:    return (a < b) ? 32'd1 : 32'd0;
            3'd4:    return a ^ b;
            3'd5:    return alt ? sra : a >> b[4:0];
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branch_taken(input logic [2:0] f3, input logic [31:0] a,
                                          input logic [31:0] b);
        case (f3)
            3'd0:    return a == b;
            3'd1:    return a != b;
            3'd4:    return $signed(a) < $signed(b);
            3'd5:    return $signed(a) >= $signed(b);
            3'd6:    return a < b;
            default: return a >= b;
        endcase
    endfunction

    // one fetch from the model, checked before the edge and retired after it
    task automatic execute_random_instr();
        rv_pkg::instr_t word;
        logic [31:0] r;
        logic [3:0]  kind;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        logic        alt;
        logic [11:0] imm12;
        logic [31:0] imm;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] addr;
        logic        writes;
        logic [31:0] e_data;
        logic [31:0] e_pc;
        logic        st_en;
        r = rand_bits(17);
        rd = {2'b00, r[2:0]};  // x0..x7 for more reuse
        rs1 = {2'b00, r[5:3]};
        rs2 = {2'b00, r[8:6]};
        f3 = r[11:9];
        alt = r[12];
        kind = r[16:13];
        r = rand_bits(12);
        imm12 = r[11:0];
        word = 32'd0;
        a = m_regs[rs1];
        b = m_regs[rs2];
        writes = 1'b0;
        e_data = 32'd0;
        e_pc = m_pc + 32'd4;
        st_en = 1'b0;
        case (kind)
            4'd0, 4'd1, 4'd2, 4'd3:
            begin
                if (f3 != 3'd0 && f3 != 3'd5)
                    alt = 1'b0;
                word.r.opcode = rv_pkg::OP_R;
                word.r.rd = rd;
                word.r.rs1 = rs1;
                word.r.rs2 = rs2;
                word.r.funct3 = f3;
                word.r.funct7 = alt ? 7'h20 : 7'h00;
                e_data = alu_model(f3, alt, a, b);
                writes = 1'b1;
            end
            4'd4, 4'd5, 4'd6:
            begin
                if (f3 != 3'd5)
                    alt = 1'b0;
                if (f3 == 3'd1)
                    imm12[11:5] = 7'h00;
                if (f3 == 3'd5)
                    imm12[11:5] = alt ? 7'h20 : 7'h00;
                imm = {{20{imm12[11]}}, imm12};
                word.i.opcode = rv_pkg::OP_IMM;
                word.i.rd = rd;
                word.i.rs1 = rs1;
                word.i.funct3 = f3;
                word.i.imm = imm12;
                e_data = alu_model(f3, alt, a, imm);
                writes = 1'b1;
            end
            4'd7, 4'd8:
            begin
                imm = {{20{imm12[11]}}, imm12};
                word.s.opcode = rv_pkg::OP_STORE;
                word.s.rs1 = rs1;
                word.s.rs2 = rs2;
                word.s.funct3 = 3'b010;
                word.s.imm_hi = imm12[11:5];
                word.s.imm_lo = imm12[4:0];
                addr = a + imm;
                st_en = 1'b1;
            end
            4'd9, 4'd10:
            begin
                imm = {{20{imm12[11]}}, imm12};
                word.i.opcode = rv_pkg::OP_LOAD;
                word.i.rd = rd;
                word.i.rs1 = rs1;
                word.i.funct3 = 3'b010;
                word.i.imm = imm12;
                addr = a + imm;
                e_data = m_mem[(addr >> 2) % DMEM_WORDS];
                writes = 1'b1;
            end
            4'd11, 4'd12:
            begin
                if (f3 == 3'd2 || f3 == 3'd3)
                    f3 = f3 + 3'd4;  // no branch on 010 and 011
                imm = {{19{imm12[11]}}, imm12, 1'b0};
                word.b.opcode = rv_pkg::OP_BRANCH;
                word.b.rs1 = rs1;
                word.b.rs2 = rs2;
                word.b.funct3 = f3;
                word.b.imm12 = imm12[11];
                word.b.imm11 = imm12[10];
                word.b.imm10_5 = imm12[9:4];
                word.b.imm4_1 = imm12[3:0];
                if (branch_taken(f3, a, b))
                    e_pc = m_pc + imm;
            end
            4'd13:
            begin
                r = rand_bits(20);
                imm = {{11{r[19]}}, r[19:0], 1'b0};
                word.j.opcode = rv_pkg::OP_JAL;
                word.j.rd = rd;
                word.j.imm20 = r[19];
                word.j.imm19_12 = r[18:11];
                word.j.imm11 = r[10];
                word.j.imm10_1 = r[9:0];
                e_data = m_pc + 32'd4;
                e_pc = m_pc + imm;
                writes = 1'b1;
            end
            4'd14:
            begin
                if (alt)
                begin
                    imm = {{20{imm12[11]}}, imm12};
                    word.i.opcode = rv_pkg::OP_JALR;
                    word.i.rd = rd;
                    word.i.rs1 = rs1;
                    word.i.imm = imm12;
                    e_data = m_pc + 32'd4;
                    e_pc = (a + imm) & ~32'd1;
                end
                else
                begin
                    r = rand_bits(20);
                    word.u.opcode = rv_pkg::OP_LUI;
                    word.u.rd = rd;
                    word.u.imm = r[19:0];
                    e_data = {r[19:0], 12'd0};
                end
                writes = 1'b1;
            end
            default:
            begin
                r = rand_bits(32);
                word = r;
                if (is_supported(word.r.opcode))
                    word.r.opcode = 7'b1110011;  // system opcode is not supported
            end
        endcase
        instr = word;
        #(CLK_PERIOD / 4);
        compare("pc", pc, m_pc);
        compare("wb_en", {31'd0, wb_en}, {31'd0, writes && rd != 5'd0});
        if (writes && rd != 5'd0)
        begin
            compare("wb_rd", {27'd0, wb_rd}, {27'd0, rd});
            compare("wb_data", wb_data, e_data);
        end
        @(posedge clk);
        if (writes && rd != 5'd0)
            m_regs[rd] = e_data;
        if (st_en)
            m_mem[(addr >> 2) % DMEM_WORDS] = b;
        m_pc = e_pc;
    endtask

    initial
    begin
        cycles = 0;
        lfsr = 32'hb53395a5;
        rst = 1'b1;
        instr = 32'h0010_0093;  // addi x1, x0, 1 while held in reset
        m_pc = rv_pkg::RESET_PC;
        for (int k = 0; k < 32; k++)
        begin
            m_regs[k] = 32'd0;
        end
        for (int k = 0; k < DMEM_WORDS; k++)
        begin
            m_mem[k] = 32'd0;
        end
        repeat (RESET_CYCLES - 1) @(posedge clk);
        @(negedge clk);
        compare("wb_en in reset", {31'd0, wb_en}, 32'd0);
        compare("pc in reset", pc, rv_pkg::RESET_PC);
        @(posedge clk);
        for (int n = 0; n < NUM_INSTR; n++)
        begin
            @(negedge clk);
            rst = 1'b0;
            execute_random_instr();
        end
        $display("Done: no errors");
        $finish;
    end

endmodule

`default_nettype wire

// ==== build.f ====
rv_pkg.sv
control_unit.sv
reg_file.sv
alu.sv
pc_unit.sv
data_mem.sv
rv_core.sv
tb_rv_core.sv
